//--- common/io_pkg.sv
package io_pkg;

	// ========================================
	// channel words
	// ========================================

	localparam int data_w = 32;
	localparam int chan_w = 3;

	// push channels
	localparam logic [chan_w-1:0] ch_hex = 3'd0;
	localparam logic [chan_w-1:0] ch_led = 3'd1;
	localparam logic [chan_w-1:0] ch_palette = 3'd2;
	localparam logic [chan_w-1:0] ch_pixel = 3'd3;
	localparam logic [chan_w-1:0] ch_uart_tx = 3'd4;

	// pop channels
	localparam logic [chan_w-1:0] ch_uart = 3'd0;
	localparam logic [chan_w-1:0] ch_timer = 3'd1;

	// ========================================
	// board timing
	// ========================================

	// clocks per serial bit, same for both directions
	localparam int baud_div = 16;

	// video counts are in clocks along a line and in lines down a frame
	localparam int line_clks = 1600;
	localparam int hsync_clks = 192;
	localparam int frame_lines = 525;
	localparam int vsync_lines = 2;
	localparam int active_x_first = 285;
	localparam int active_x_last = 1565;
	localparam int active_y_first = 35;
	localparam int active_y_last = 514;

	localparam int fifo_aw = 8;

	// one push word seen by the panel as four digit slots and by the video
	// side as a palette command
	typedef union packed {
		// slot n holds segments in [7:1] and its load bit in [0]
		logic [3:0][7:0] hex;
		struct packed {
			logic [23:0] rgb;
			logic we;
			logic restart;
			logic [1:0] rsvd;
			logic [3:0] index;
		} pal;
	} io_word_t;

endpackage

//--- design/io_ctrl.sv
`timescale 1ns/1ps

module io_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic push_valid,
	input  logic [io_pkg::chan_w-1:0] push_chan,
	input  io_pkg::io_word_t push_data,
	input  logic pop_valid,
	input  logic [io_pkg::chan_w-1:0] pop_chan,
	input  logic tx_free,
	input  logic rx_valid,
	input  logic [7:0] rx_byte,
	input  logic fifo_full,
	output logic push_retry,
	output logic [io_pkg::data_w-1:0] pop_data,
	output logic hex_we,
	output logic led_we,
	output logic tx_we,
	output logic rx_clr,
	output logic pal_we,
	output logic frame_restart,
	output logic pix_we
);
	import io_pkg::*;

	logic push_ok;
	logic [data_w-1:0] timer;

	// ========================================
	// push side
	// ========================================

	// only the two buffered devices can push back
	always_comb begin
		case (push_chan)
			ch_pixel: push_retry = fifo_full;
			ch_uart_tx: push_retry = !tx_free;
			default: push_retry = 1'b0;
		endcase
	end

	assign push_ok = push_valid && !push_retry;

	assign hex_we = push_ok && push_chan == ch_hex;
	assign led_we = push_ok && push_chan == ch_led;
	assign pix_we = push_ok && push_chan == ch_pixel;
	assign tx_we = push_ok && push_chan == ch_uart_tx;
	assign pal_we = push_ok && push_chan == ch_palette && push_data.pal.we;
	assign frame_restart = push_ok && push_chan == ch_palette && push_data.pal.restart;

	// ========================================
	// pop side
	// ========================================

	// reading a valid byte consumes it
	assign rx_clr = pop_valid && pop_chan == ch_uart && rx_valid;

	always_comb begin
		case (pop_chan)
			ch_uart: pop_data = {tx_free, rx_valid, {(data_w - 10){1'b0}}, rx_byte};
			ch_timer: pop_data = timer;
			default: pop_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			timer <= '0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	a_one_device: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({hex_we, led_we, tx_we, pal_we | frame_restart, pix_we}))
		else $error("more than one device strobed in one clock");

endmodule

//--- design/panel_out.sv
`timescale 1ns/1ps

module panel_out (
	input  logic clk,
	input  logic arst_n,
	input  logic hex_we,
	input  logic led_we,
	input  io_pkg::io_word_t push_data,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [9:0] ledr,
	output logic [7:0] ledg
);

	logic [3:0][6:0] hex_q;

	// segment pins are active low, so a blank digit is all ones
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hex_q <= '1;
		end else if (hex_we) begin
			for (int i = 0; i < 4; i++) begin
				if (push_data.hex[i][0]) begin
					hex_q[i] <= ~push_data.hex[i][7:1];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ledr <= '0;
			ledg <= '0;
		end else if (led_we) begin
			{ledr, ledg} <= push_data[17:0];
		end
	end

	assign hex0 = hex_q[0];
	assign hex1 = hex_q[1];
	assign hex2 = hex_q[2];
	assign hex3 = hex_q[3];

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input  logic clk,
	input  logic arst_n,
	input  logic tx_we,
	input  logic [7:0] tx_byte,
	output logic tx_free,
	output logic uart_out
);
	import io_pkg::*;

	logic [$clog2(baud_div)-1:0] div_cnt;
	logic bit_tick;
	logic hold_full;
	logic [7:0] hold_byte;
	logic [9:0] shift_q;
	logic [3:0] bits_left;
	logic load;

	// bit boundaries are free running, so a frame waits for the next one
	assign bit_tick = int'(div_cnt) == baud_div - 1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
		end else if (bit_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// a waiting byte goes out as the stop bit of the previous one ends
	assign load = bit_tick && bits_left <= 4'd1 && hold_full;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hold_full <= 1'b0;
		end else if (tx_we) begin
			hold_full <= 1'b1;
		end else if (load) begin
			hold_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (tx_we) begin
			hold_byte <= tx_byte;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			shift_q <= '1;
			bits_left <= '0;
		end else if (load) begin
			shift_q <= {1'b1, hold_byte, 1'b0};
			bits_left <= 4'd10;
		end else if (bit_tick) begin
			if (bits_left > 4'd1) begin
				shift_q <= {1'b1, shift_q[9:1]};
				bits_left <= bits_left - 1'b1;
			end else begin
				shift_q <= '1;
				bits_left <= '0;
			end
		end
	end

	assign uart_out = shift_q[0];
	assign tx_free = !hold_full;

	a_tx_we_free: assert property (@(posedge clk) disable iff (!arst_n) tx_we |-> tx_free)
		else $error("transmit push while the holding register is full");

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input  logic clk,
	input  logic arst_n,
	input  logic uart_in,
	input  logic rx_clr,
	output logic rx_valid,
	output logic [7:0] rx_byte
);
	import io_pkg::*;

	logic [1:0] sync_q;
	logic line;
	logic line_prev;
	logic fall;
	logic busy;
	logic [$clog2(baud_div)-1:0] tick_cnt;
	logic [3:0] bit_idx;
	logic sample;
	logic stop_ok;
	logic [7:0] data_q;

	assign line = sync_q[1];
	assign fall = line_prev && !line;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= '1;
			line_prev <= 1'b1;
		end else begin
			sync_q <= {sync_q[0], uart_in};
			line_prev <= line;
		end
	end

	// ========================================
	// bit timing
	// ========================================

	// bit 0 is the start bit, 1 to 8 carry data and 9 is the stop bit
	assign sample = busy && int'(tick_cnt) == baud_div / 2;
	assign stop_ok = sample && bit_idx == 4'd9 && line;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			tick_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			if (fall) begin
				busy <= 1'b1;
				tick_cnt <= '0;
				bit_idx <= '0;
			end
		end else begin
			if (int'(tick_cnt) == baud_div - 1) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
			if (sample) begin
				bit_idx <= bit_idx + 1'b1;
				// a start bit that is high again by mid-bit was a glitch
				if ((bit_idx == 4'd0 && line) || bit_idx == 4'd9) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
			data_q <= {line, data_q[7:1]};
		end
		if (stop_ok) begin
			rx_byte <= data_q;
		end
	end

	// a new byte wins over a clear in the same clock
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_valid <= 1'b0;
		end else if (stop_ok) begin
			rx_valid <= 1'b1;
		end else if (rx_clr) begin
			rx_valid <= 1'b0;
		end
	end

endmodule

//--- video/video_timing.sv
`timescale 1ns/1ps

module video_timing (
	input  logic clk,
	input  logic arst_n,
	input  logic frame_restart,
	output logic vid_hs,
	output logic vid_vs,
	output logic vid_clk,
	output logic pix_fetch,
	output logic pix_step,
	output logic de_next
);
	import io_pkg::*;

	logic [$clog2(line_clks)-1:0] h_cnt;
	logic [$clog2(line_clks)-1:0] h_next;
	logic [$clog2(frame_lines)-1:0] v_cnt;
	logic [$clog2(frame_lines)-1:0] v_next;
	logic line_end;
	logic frame_end;
	logic x_on;
	logic y_on;

	assign line_end = int'(h_cnt) == line_clks - 1;
	assign frame_end = int'(v_cnt) == frame_lines - 1;

	always_comb begin
		h_next = h_cnt + 1'b1;
		v_next = v_cnt;
		if (frame_restart) begin
			h_next = '0;
			v_next = '0;
		end else if (line_end) begin
			h_next = '0;
			if (frame_end) begin
				v_next = '0;
			end else begin
				v_next = v_cnt + 1'b1;
			end
		end
	end

	// syncs are registered from the next counts so they line up with them
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
			vid_hs <= 1'b0;
			vid_vs <= 1'b0;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			vid_hs <= int'(h_next) >= hsync_clks;
			vid_vs <= int'(v_next) >= vsync_lines;
		end
	end

	assign vid_clk = h_cnt[0];

	// ========================================
	// pixel window
	// ========================================

	assign x_on = int'(h_cnt) >= active_x_first && int'(h_cnt) < active_x_last;
	assign y_on = int'(v_cnt) >= active_y_first && int'(v_cnt) <= active_y_last;

	// fetch, shifter load and palette register each take a clock, so the
	// visible pixels trail the fetch window by two clocks
	assign pix_fetch = x_on && y_on && h_cnt[3:0] == active_x_first[3:0];
	assign pix_step = h_cnt[0];
	assign de_next = y_on && int'(h_cnt) >= active_x_first + 2
		&& int'(h_cnt) < active_x_last + 2;

	a_h_range: assert property (@(posedge clk) disable iff (!arst_n) int'(h_cnt) < line_clks)
		else $error("horizontal count ran past the line");

endmodule

//--- video/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo (
	input  logic clk,
	input  logic arst_n,
	input  logic clear,
	input  logic we,
	input  logic [io_pkg::data_w-1:0] wdata,
	input  logic re,
	output logic [io_pkg::data_w-1:0] rdata,
	output logic full,
	output logic empty
);
	import io_pkg::*;

	logic [data_w-1:0] mem [2**fifo_aw];
	logic [fifo_aw-1:0] wr_ptr;
	logic [fifo_aw-1:0] rd_ptr;
	logic [fifo_aw:0] count;
	logic do_wr;
	logic do_rd;

	// count tops out at the depth, which is the only value with the msb set
	assign full = count[fifo_aw];
	assign empty = count == '0;
	assign do_wr = we && !full;
	assign do_rd = re && !empty;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;
		end
		if (do_rd) begin
			rdata <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n) we |-> !full)
		else $error("pixel word written into a full FIFO");
	a_no_read_empty: assert property (@(posedge clk) disable iff (!arst_n)
		re && empty && !clear |=> $stable(rd_ptr))
		else $error("read pointer moved on an empty FIFO");

endmodule

//--- video/video_pixel.sv
`timescale 1ns/1ps

module video_pixel (
	input  logic clk,
	input  logic arst_n,
	input  logic pal_we,
	input  io_pkg::io_word_t push_data,
	input  logic pix_fetch,
	input  logic pix_step,
	input  logic de_next,
	input  logic [io_pkg::data_w-1:0] fifo_word,
	input  logic fifo_empty,
	output logic [7:0] vid_r,
	output logic [7:0] vid_g,
	output logic [7:0] vid_b,
	output logic vid_de
);
	import io_pkg::*;

	logic [23:0] palette [16];
	logic load_q;
	logic hit_q;
	logic [data_w-1:0] shift_q;

	always_ff @(posedge clk) begin
		if (pal_we) begin
			palette[push_data.pal.index] <= push_data.pal.rgb;
		end
	end

	// the FIFO word arrives one clock after the fetch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			load_q <= 1'b0;
			hit_q <= 1'b0;
		end else begin
			load_q <= pix_fetch;
			hit_q <= pix_fetch && !fifo_empty;
		end
	end

	// eight nibbles per word, most significant first, two clocks each
	always_ff @(posedge clk) begin
		if (load_q) begin
			shift_q <= hit_q ? fifo_word : '0;
		end else if (pix_step) begin
			shift_q <= {shift_q[data_w-5:0], 4'h0};
		end
		if (pix_step) begin
			{vid_r, vid_g, vid_b} <= palette[shift_q[data_w-1 -: 4]];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vid_de <= 1'b0;
		end else if (pix_step) begin
			vid_de <= de_next;
		end
	end

endmodule

//--- design/io_top.sv
`timescale 1ns/1ps

module io_top (
	input  logic clk,
	input  logic arst_n,
	input  logic push_valid,
	input  logic [io_pkg::chan_w-1:0] push_chan,
	input  io_pkg::io_word_t push_data,
	output logic push_retry,
	input  logic pop_valid,
	input  logic [io_pkg::chan_w-1:0] pop_chan,
	output logic [io_pkg::data_w-1:0] pop_data,
	input  logic uart_in,
	output logic uart_out,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [9:0] ledr,
	output logic [7:0] ledg,
	output logic [7:0] vid_r,
	output logic [7:0] vid_g,
	output logic [7:0] vid_b,
	output logic vid_clk,
	output logic vid_de,
	output logic vid_hs,
	output logic vid_vs
);
	import io_pkg::*;

	logic hex_we;
	logic led_we;
	logic tx_we;
	logic tx_free;
	logic rx_clr;
	logic rx_valid;
	logic [7:0] rx_byte;
	logic pal_we;
	logic frame_restart;
	logic pix_we;
	logic fifo_full;
	logic fifo_empty;
	logic [data_w-1:0] fifo_word;
	logic pix_fetch;
	logic pix_step;
	logic de_next;

	io_ctrl ctrl0 (
		.clk(clk),
		.arst_n(arst_n),
		.push_valid(push_valid),
		.push_chan(push_chan),
		.push_data(push_data),
		.pop_valid(pop_valid),
		.pop_chan(pop_chan),
		.tx_free(tx_free),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.fifo_full(fifo_full),
		.push_retry(push_retry),
		.pop_data(pop_data),
		.hex_we(hex_we),
		.led_we(led_we),
		.tx_we(tx_we),
		.rx_clr(rx_clr),
		.pal_we(pal_we),
		.frame_restart(frame_restart),
		.pix_we(pix_we)
	);

	panel_out panel0 (
		.clk(clk),
		.arst_n(arst_n),
		.hex_we(hex_we),
		.led_we(led_we),
		.push_data(push_data),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.ledr(ledr),
		.ledg(ledg)
	);

	uart_tx tx0 (
		.clk(clk),
		.arst_n(arst_n),
		.tx_we(tx_we),
		.tx_byte(push_data[7:0]),
		.tx_free(tx_free),
		.uart_out(uart_out)
	);

	uart_rx rx0 (
		.clk(clk),
		.arst_n(arst_n),
		.uart_in(uart_in),
		.rx_clr(rx_clr),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte)
	);

	video_timing timing0 (
		.clk(clk),
		.arst_n(arst_n),
		.frame_restart(frame_restart),
		.vid_hs(vid_hs),
		.vid_vs(vid_vs),
		.vid_clk(vid_clk),
		.pix_fetch(pix_fetch),
		.pix_step(pix_step),
		.de_next(de_next)
	);

	// a frame restart also drops any queued pixel words
	pixel_fifo fifo0 (
		.clk(clk),
		.arst_n(arst_n),
		.clear(frame_restart),
		.we(pix_we),
		.wdata(push_data),
		.re(pix_fetch),
		.rdata(fifo_word),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	video_pixel pixel0 (
		.clk(clk),
		.arst_n(arst_n),
		.pal_we(pal_we),
		.push_data(push_data),
		.pix_fetch(pix_fetch),
		.pix_step(pix_step),
		.de_next(de_next),
		.fifo_word(fifo_word),
		.fifo_empty(fifo_empty),
		.vid_r(vid_r),
		.vid_g(vid_g),
		.vid_b(vid_b),
		.vid_de(vid_de)
	);

endmodule

//--- bench/tb_io_top.sv
`timescale 1ns/1ps

module tb_io_top;
	import io_pkg::*;

	localparam int frame_clks = line_clks * frame_lines;
	localparam int fifo_depth = 2 ** fifo_aw;
	localparam int window_clks = (active_x_last - active_x_first)
		* (active_y_last - active_y_first + 1);
	// one frame for the sync test, most of another for the pixels, plus serial frames
	localparam int watchdog_clks = 2 * frame_clks + 10 * 10 * baud_div + 20000;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;

	logic clk;
	logic arst_n;
	logic push_valid;
	logic [chan_w-1:0] push_chan;
	io_word_t push_data;
	logic push_retry;
	logic pop_valid;
	logic [chan_w-1:0] pop_chan;
	logic [data_w-1:0] pop_data;
	logic uart_in;
	logic uart_out;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [9:0] ledr;
	logic [7:0] ledg;
	logic [7:0] vid_r;
	logic [7:0] vid_g;
	logic [7:0] vid_b;
	logic vid_clk;
	logic vid_de;
	logic vid_hs;
	logic vid_vs;

	logic [31:0] lfsr = 32'heba6_549d;
	int err_count = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string test_name = "";

	io_top dut0 (
		.clk(clk),
		.arst_n(arst_n),
		.push_valid(push_valid),
		.push_chan(push_chan),
		.push_data(push_data),
		.push_retry(push_retry),
		.pop_valid(pop_valid),
		.pop_chan(pop_chan),
		.pop_data(pop_data),
		.uart_in(uart_in),
		.uart_out(uart_out),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.ledr(ledr),
		.ledg(ledg),
		.vid_r(vid_r),
		.vid_g(vid_g),
		.vid_b(vid_b),
		.vid_clk(vid_clk),
		.vid_de(vid_de),
		.vid_hs(vid_hs),
		.vid_vs(vid_vs)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (watchdog_clks) @(posedge clk);
		$display("watchdog expired after %0d clocks during test %s", watchdog_clks, test_name);
		$display("sim failed");
		$finish;
	end

	// only the pixel and transmit channels may ever hold a push back
	a_retry_channels: assert property (@(posedge clk) disable iff (!arst_n)
		(push_chan != ch_pixel && push_chan != ch_uart_tx) |-> !push_retry)
		else begin
			err_count++;
			$display("%s: push_retry was high on channel %0d", test_name, push_chan);
		end

	// ========================================
	// helpers
	// ========================================

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ lfsr_taps;
		end
		return n;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] palette_word(input logic [23:0] rgb, input logic we,
		input logic restart, input logic [3:0] index);
		return {rgb, we, restart, 2'b00, index};
	endfunction

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
			err_count++;
		end
	endtask

	task automatic require_true(input logic cond, input string msg);
		assert (cond === 1'b1) else begin
			$display("%s: %s", test_name, msg);
			err_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = err_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_count == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, err_count - errors_at_start);
		end
	endtask

	// every stimulus task starts and ends 1 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic push_word(input logic [chan_w-1:0] chan, input logic [31:0] data);
		push_valid = 1'b1;
		push_chan = chan;
		push_data = data;
		@(negedge clk);
		while (push_retry) begin
			@(negedge clk);
		end
		next_cycle();
		push_valid = 1'b0;
	endtask

	task automatic peek_word(input logic [chan_w-1:0] chan, output logic [31:0] word);
		pop_chan = chan;
		pop_valid = 1'b0;
		@(negedge clk);
		word = pop_data;
		next_cycle();
	endtask

	task automatic pop_word(input logic [chan_w-1:0] chan, output logic [31:0] word);
		pop_chan = chan;
		pop_valid = 1'b1;
		@(negedge clk);
		word = pop_data;
		next_cycle();
		pop_valid = 1'b0;
	endtask

	task automatic send_serial(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_in = frame[i];
			repeat (baud_div) next_cycle();
		end
	endtask

	// the first low sample follows the edge that started the start bit
	task automatic check_tx_frame(input logic [7:0] b);
		int wait_clks;
		wait_clks = 0;
		@(negedge clk);
		while (uart_out && wait_clks < 2 * baud_div) begin
			@(negedge clk);
			wait_clks++;
		end
		require_true(!uart_out, "no start bit appeared on uart_out");
		if (!uart_out) begin
			repeat (baud_div / 2) @(negedge clk);
			compare_value("start bit", 0, uart_out);
			for (int i = 0; i < 8; i++) begin
				repeat (baud_div) @(negedge clk);
				compare_value("data bit", b[i], uart_out);
			end
			repeat (baud_div) @(negedge clk);
			compare_value("stop bit", 1, uart_out);
		end
		next_cycle();
	endtask

	// ========================================
	// tests
	// ========================================

	task automatic reset_state();
		logic [31:0] word;
		start_test("reset");
		@(negedge clk);
		compare_value("hex pins", 28'hfff_ffff, {hex3, hex2, hex1, hex0});
		compare_value("leds", 0, {ledr, ledg});
		compare_value("uart_out", 1, uart_out);
		compare_value("vid_de", 0, vid_de);
		compare_value("push_retry", 0, push_retry);
		next_cycle();
		peek_word(ch_uart, word);
		compare_value("tx free and rx valid", 2'b10, word[31:30]);
		end_test();
	endtask

	task automatic panel_outputs();
		logic [31:0] word;
		logic [6:0] exp_hex [4];
		start_test("hex_led");
		for (int i = 0; i < 4; i++) begin
			exp_hex[i] = 7'h7f;
		end
		for (int k = 0; k < 4; k++) begin
			word = random_bits(32);
			push_word(ch_hex, word);
			for (int i = 0; i < 4; i++) begin
				if (word[8 * i]) begin
					exp_hex[i] = ~word[8 * i + 1 +: 7];
				end
			end
			@(negedge clk);
			compare_value("hex0", exp_hex[0], hex0);
			compare_value("hex1", exp_hex[1], hex1);
			compare_value("hex2", exp_hex[2], hex2);
			compare_value("hex3", exp_hex[3], hex3);
			next_cycle();
			word = random_bits(32);
			push_word(ch_led, word);
			@(negedge clk);
			compare_value("ledr and ledg", word[17:0], {ledr, ledg});
			next_cycle();
		end
		end_test();
	endtask

	task automatic serial_transmit();
		logic [7:0] b;
		start_test("uart_tx");
		for (int k = 0; k < 3; k++) begin
			b = random_bits(8);
			push_word(ch_uart_tx, {24'h0, b});
			if (k == 0) begin
				// the byte still sits in the holding register
				push_valid = 1'b1;
				push_chan = ch_uart_tx;
				push_data = 32'h55;
				@(negedge clk);
				compare_value("retry while busy", 1, push_retry);
				next_cycle();
				push_valid = 1'b0;
			end
			check_tx_frame(b);
		end
		end_test();
	endtask

	task automatic serial_receive();
		logic [7:0] b;
		logic [31:0] word;
		int wait_clks;
		start_test("uart_rx");
		for (int k = 0; k < 2; k++) begin
			b = random_bits(8);
			send_serial(b);
			wait_clks = 0;
			peek_word(ch_uart, word);
			while (!word[30] && wait_clks < 2 * baud_div) begin
				peek_word(ch_uart, word);
				wait_clks++;
			end
			require_true(word[30], "received byte never became valid");
			pop_word(ch_uart, word);
			compare_value("valid flag", 1, word[30]);
			compare_value("received byte", b, word[7:0]);
			peek_word(ch_uart, word);
			compare_value("valid after clear", 0, word[30]);
		end
		end_test();
	endtask

	task automatic timer_count();
		logic [31:0] t1;
		logic [31:0] t2;
		int n_clks;
		start_test("timer");
		for (int k = 0; k < 2; k++) begin
			n_clks = random_bits(6) + 1;
			pop_word(ch_timer, t1);
			repeat (n_clks - 1) next_cycle();
			pop_word(ch_timer, t2);
			compare_value("timer difference", n_clks, t2 - t1);
		end
		end_test();
	endtask

	task automatic video_sync();
		int falls;
		int last_fall;
		int vs_low;
		int de_high;
		int bad_de;
		int bad_clk;
		logic prev_hs;
		start_test("video_timing");
		falls = 0;
		last_fall = 0;
		vs_low = 0;
		de_high = 0;
		bad_de = 0;
		bad_clk = 0;
		// the restart puts the line start on the first sample
		prev_hs = 1'b1;
		push_word(ch_palette, palette_word(24'h0, 1'b0, 1'b1, 4'h0));
		for (int c = 0; c < frame_clks; c++) begin
			@(negedge clk);
			if (prev_hs && !vid_hs) begin
				if (falls > 0) begin
					compare_value("hsync period", line_clks, c - last_fall);
				end
				last_fall = c;
				falls++;
			end
			if (!prev_hs && vid_hs) begin
				compare_value("hsync low width", hsync_clks, c - last_fall);
			end
			prev_hs = vid_hs;
			// the horizontal count is the clock index within the line
			if (vid_clk !== ((c % line_clks) % 2 == 1)) begin
				bad_clk++;
			end
			if (!vid_vs) begin
				vs_low++;
			end
			if (vid_de) begin
				de_high++;
				if (c / line_clks < active_y_first || c / line_clks > active_y_last) begin
					bad_de++;
				end
			end
		end
		next_cycle();
		compare_value("hsync falls per frame", frame_lines, falls);
		compare_value("vsync low clocks", vsync_lines * line_clks, vs_low);
		compare_value("vid_clk against horizontal count", 0, bad_clk);
		compare_value("vid_de outside window lines", 0, bad_de);
		compare_value("vid_de clocks per frame", window_clks, de_high);
		end_test();
	endtask

	task automatic pixel_stream();
		logic [23:0] pal_model [16];
		logic [31:0] pix_words [fifo_depth];
		logic [3:0] nib;
		int n;
		int p;
		int c;
		start_test("pixels");
		for (int i = 0; i < 16; i++) begin
			pal_model[i] = random_bits(24);
			push_word(ch_palette, palette_word(pal_model[i], 1'b1, 1'b0, i[3:0]));
		end
		push_word(ch_palette, palette_word(24'h0, 1'b0, 1'b1, 4'h0));
		for (int i = 0; i < fifo_depth; i++) begin
			pix_words[i] = random_bits(32);
			push_word(ch_pixel, pix_words[i]);
		end
		push_valid = 1'b1;
		push_chan = ch_pixel;
		push_data = random_bits(32);
		@(negedge clk);
		compare_value("retry when full", 1, push_retry);
		next_cycle();
		push_valid = 1'b0;
		// each pixel is held for two clocks
		n = 0;
		c = 0;
		while (n < 2 * 8 * fifo_depth && c < (active_y_first + 8) * line_clks) begin
			@(negedge clk);
			c++;
			if (vid_de) begin
				p = n / 2;
				nib = pix_words[p / 8][(7 - p % 8) * 4 +: 4];
				compare_value("pixel rgb", pal_model[nib], {vid_r, vid_g, vid_b});
				n++;
			end
		end
		require_true(n == 2 * 8 * fifo_depth, "pixel stream stopped before all words were shown");
		next_cycle();
		end_test();
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		arst_n = 1'b0;
		push_valid = 1'b0;
		push_chan = '0;
		push_data = '0;
		pop_valid = 1'b0;
		pop_chan = '0;
		uart_in = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		reset_state();
		panel_outputs();
		serial_transmit();
		serial_receive();
		timer_count();
		video_sync();
		pixel_stream();
		$display("%0d tests, %0d ok, %0d failing, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, err_count);
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- project.f
common/io_pkg.sv
design/io_ctrl.sv
design/panel_out.sv
uart/uart_tx.sv
uart/uart_rx.sv
video/video_timing.sv
video/pixel_fifo.sv
video/video_pixel.sv
design/io_top.sv
bench/tb_io_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_io_top
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
